// ==== Bender.yml ====
package:
  name: audio_engine

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/audio_pkg.sv
      - logic/iomem_decode.sv
      - logic/i2s_clock.sv
      - logic/i2s_tx.sv
      - logic/i2s_rx.sv
      - logic/dpram.sv
      - logic/mix_sequencer.sv
      - logic/audio_engine.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/audio_engine_tb.sv

// ==== audio_engine.f ====
+incdir+logic
logic/audio_pkg.sv
logic/iomem_decode.sv
logic/i2s_clock.sv
logic/i2s_tx.sv
logic/i2s_rx.sv
logic/dpram.sv
logic/mix_sequencer.sv
logic/audio_engine.sv
verification/audio_engine_tb.sv

// ==== logic/audio_cfg.svh ====
`ifndef AUDIO_CFG_SVH
`define AUDIO_CFG_SVH

// Peripheral base, each region is one 256 byte page above it
`define AE_BASE        16'h6000
`define AE_COEF_OFS    16'h0000
`define AE_RESULT_OFS  16'h0100
`define AE_STATUS_OFS  16'h0200
`define AE_RESET_OFS   16'h0300
`define AE_INPUT_OFS   16'h0400

// Audio RAM geometry
`define AE_CHANNELS    8
`define AE_FRAMES      256

// Coefficient RAM depth
`define AE_COEF_WORDS  256

// ck ticks per sck half period
`define AE_I2S_DIVIDER 4

`define AE_BUS_WIDTH   32

`endif

// ==== logic/audio_engine.sv ====
`timescale 1ns/1ps
`include "audio_cfg.svh"

module audio_engine (
    input  logic                 ck,
    input  logic                 arst_n,
    input  logic                 iomem_valid,
    output logic                 iomem_ready,
    input  logic [3:0]           iomem_wstrb,
    input  audio_pkg::bus_word_t iomem_addr,
    input  audio_pkg::bus_word_t iomem_wdata,
    output audio_pkg::bus_word_t iomem_rdata,
    output logic                 sck,
    output logic                 ws,
    output logic                 sd_out,
    input  logic                 sd_in0
);

    localparam logic [15:0] coef_base   = `AE_BASE + `AE_COEF_OFS;
    localparam logic [15:0] result_base = `AE_BASE + `AE_RESULT_OFS;
    localparam logic [15:0] status_base = `AE_BASE + `AE_STATUS_OFS;
    localparam logic [15:0] reset_base  = `AE_BASE + `AE_RESET_OFS;
    localparam logic [15:0] input_base  = `AE_BASE + `AE_INPUT_OFS;
    localparam int audio_words = `AE_CHANNELS * `AE_FRAMES;
    localparam audio_pkg::chan_t last_chan = audio_pkg::chan_t'(`AE_CHANNELS - 1);
    localparam int ab = $bits(audio_pkg::audio_addr_t);
    localparam int cb = $bits(audio_pkg::coef_addr_t);

    logic coef_ready;
    logic coef_we;
    logic result_ready;
    logic result_re;
    logic status_ready;
    logic status_we;
    logic status_re;
    logic reset_ready;
    logic reset_we;
    logic input_ready;
    logic input_we;

    // Bit 0 is host write mode, upper bits the host frame
    logic [$bits(audio_pkg::frame_t):0] ctrl;
    logic                  host_mode;
    audio_pkg::frame_t     host_frame;
    audio_pkg::frame_t     frame;
    audio_pkg::frame_t     frame_cnt;

    logic                   i2s_en;
    audio_pkg::frame_posn_t frame_posn;
    audio_pkg::sample_t     mic_left;
    audio_pkg::sample_t     mic_right;
    audio_pkg::sample_t     mic_sample;
    audio_pkg::chan_t       cap_chan;
    logic                   cap_busy;
    logic                   cap_done;
    logic                   cap_start_cond;
    logic                   start_q;

    logic                   audio_we;
    audio_pkg::audio_addr_t audio_waddr;
    audio_pkg::sample_t     audio_wdata;
    audio_pkg::audio_addr_t seq_audio_addr;
    audio_pkg::sample_t     audio_rdata;
    audio_pkg::coef_addr_t  seq_coef_addr;
    audio_pkg::coef_t       coef_rdata;

    logic [1:0]           run_cnt;
    logic                 run_rst;
    logic                 out_sel;
    audio_pkg::sample_t   out_data;
    logic                 out_we;
    logic                 done;
    logic                 error;
    audio_pkg::sample_t   left_res;
    audio_pkg::sample_t   right_res;
    logic [15:0]          result_sel;
    audio_pkg::bus_word_t rd_result;
    audio_pkg::bus_word_t rd_status;

    iomem_decode #(.region_base(coef_base)) coef_io (
        .ck(ck), .arst_n(arst_n), .valid(iomem_valid), .wstrb(iomem_wstrb), .addr(iomem_addr),
        .ready(coef_ready), .we(coef_we), .re());

    iomem_decode #(.region_base(result_base)) result_io (
        .ck(ck), .arst_n(arst_n), .valid(iomem_valid), .wstrb(iomem_wstrb), .addr(iomem_addr),
        .ready(result_ready), .we(), .re(result_re));

    iomem_decode #(.region_base(status_base)) status_io (
        .ck(ck), .arst_n(arst_n), .valid(iomem_valid), .wstrb(iomem_wstrb), .addr(iomem_addr),
        .ready(status_ready), .we(status_we), .re(status_re));

    iomem_decode #(.region_base(reset_base)) reset_io (
        .ck(ck), .arst_n(arst_n), .valid(iomem_valid), .wstrb(iomem_wstrb), .addr(iomem_addr),
        .ready(reset_ready), .we(reset_we), .re());

    iomem_decode #(.region_base(input_base)) input_io (
        .ck(ck), .arst_n(arst_n), .valid(iomem_valid), .wstrb(iomem_wstrb), .addr(iomem_addr),
        .ready(input_ready), .we(input_we), .re());

    assign host_mode  = ctrl[0];
    assign host_frame = ctrl[$bits(ctrl)-1:1];
    assign frame      = host_mode ? host_frame : frame_cnt;

    i2s_clock #(.divider(`AE_I2S_DIVIDER)) i2s_clk (
        .ck(ck), .arst_n(arst_n), .en(i2s_en), .sck(sck), .ws(ws), .frame_posn(frame_posn));

    i2s_tx tx (
        .ck(ck), .arst_n(arst_n), .en(i2s_en), .sck(sck), .frame_posn(frame_posn),
        .left(left_res), .right(right_res), .sd(sd_out));

    i2s_rx rx (
        .ck(ck), .arst_n(arst_n), .en(i2s_en), .sck(sck), .frame_posn(frame_posn),
        .sd(sd_in0), .left(mic_left), .right(mic_right));

    // Only the first microphone pair is wired, the rest read full scale
    always_comb begin
        case (cap_chan)
            audio_pkg::chan_t'(0): mic_sample = mic_left;
            audio_pkg::chan_t'(1): mic_sample = mic_right;
            default:               mic_sample = 16'sh7fff;
        endcase
    end

    // Left word begins while ws is still high at position 0
    assign cap_start_cond = ws && (frame_posn == '0);

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            frame_cnt <= '0;
            cap_chan  <= '0;
            cap_busy  <= 1'b0;
            cap_done  <= 1'b0;
            start_q   <= 1'b0;
        end else begin
            start_q  <= cap_start_cond;
            cap_done <= 1'b0;
            if (host_mode) begin
                cap_busy <= 1'b0;
            end else if (cap_start_cond && !start_q) begin
                frame_cnt <= frame_cnt + 1'b1;
                cap_chan  <= '0;
                cap_busy  <= 1'b1;
            end else if (cap_busy) begin
                cap_chan <= cap_chan + 1'b1;
                if (cap_chan == last_chan) begin
                    cap_busy <= 1'b0;
                    cap_done <= 1'b1;
                end
            end
        end
    end

    // Host owns the audio write port in host write mode
    assign audio_we    = host_mode ? input_we : cap_busy;
    assign audio_waddr = host_mode ? iomem_addr[ab+1:2] : {cap_chan, frame_cnt};
    assign audio_wdata = host_mode ? iomem_wdata[15:0] : mic_sample;

    dpram #(.bits($bits(audio_pkg::coef_t)), .words(`AE_COEF_WORDS)) coef_ram (
        .ck(ck), .we(coef_we), .waddr(iomem_addr[cb+1:2]), .wdata(iomem_wdata),
        .raddr(seq_coef_addr), .rdata(coef_rdata));

    dpram #(.bits($bits(audio_pkg::sample_t)), .words(audio_words)) audio_ram (
        .ck(ck), .we(audio_we), .waddr(audio_waddr), .wdata(audio_wdata),
        .raddr(seq_audio_addr), .rdata(audio_rdata));

    // Stretch the run request so the sequencer sees at least two reset cycles
    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n)
            run_cnt <= 2'd2;
        else if (reset_we || cap_done)
            run_cnt <= 2'd0;
        else if (run_cnt != 2'd2)
            run_cnt <= run_cnt + 1'b1;
    end

    assign run_rst = (run_cnt != 2'd2);

    mix_sequencer seq (
        .ck(ck), .arst_n(arst_n), .run_rst(run_rst), .frame(frame),
        .coef_addr(seq_coef_addr), .coef_data(coef_rdata),
        .audio_addr(seq_audio_addr), .audio_data(audio_rdata),
        .out_sel(out_sel), .out_data(out_data), .out_we(out_we),
        .done(done), .error(error));

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            left_res  <= '0;
            right_res <= '0;
        end else if (out_we) begin
            if (out_sel)
                right_res <= out_data;
            else
                left_res <= out_data;
        end
    end

    assign result_sel = iomem_addr[2] ? right_res : left_res;

    // Read data sits in its register only for the ready cycle
    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            ctrl      <= '0;
            rd_result <= '0;
            rd_status <= '0;
        end else begin
            if (status_we)
                ctrl <= iomem_wdata[$bits(ctrl)-1:0];

            if (result_re)
                rd_result <= {16'h0000, result_sel};
            else
                rd_result <= '0;

            if (status_re)
                rd_status <= iomem_addr[2] ? {mic_right, mic_left} : {30'd0, error, done};
            else
                rd_status <= '0;
        end
    end

    assign iomem_rdata = rd_result | rd_status;
    assign iomem_ready = coef_ready | result_ready | status_ready | reset_ready | input_ready;

    a_one_region: assert property (@(posedge ck) disable iff (!arst_n)
        $onehot0({coef_ready, result_ready, status_ready, reset_ready, input_ready}));

endmodule

// ==== logic/audio_pkg.sv ====
`include "audio_cfg.svh"

package audio_pkg;

    typedef logic signed [15:0] sample_t;

    typedef logic [31:0] coef_t;

    typedef logic [`AE_BUS_WIDTH-1:0] bus_word_t;

    typedef logic [$clog2(`AE_CHANNELS)-1:0] chan_t;

    typedef logic [$clog2(`AE_FRAMES)-1:0] frame_t;

    // Channel index sits above the frame index
    typedef logic [$bits(chan_t)+$bits(frame_t)-1:0] audio_addr_t;

    typedef logic [$clog2(`AE_COEF_WORDS)-1:0] coef_addr_t;

    // Room for eight Q1.15 products without overflow
    typedef logic signed [39:0] acc_t;

    typedef logic [5:0] frame_posn_t;

    typedef enum logic [1:0] {IDLE, RUN, DRAIN, FINISH} seq_state_t;

endpackage

// ==== logic/dpram.sv ====
`timescale 1ns/1ps

module dpram #(
    parameter int bits  = 16,
    parameter int words = 256
) (
    input  logic                     ck,
    input  logic                     we,
    input  logic [$clog2(words)-1:0] waddr,
    input  logic [bits-1:0]          wdata,
    input  logic [$clog2(words)-1:0] raddr,
    output logic [bits-1:0]          rdata
);

    logic [bits-1:0] mem [words];

    // Read during write to the same address returns the old word
    always_ff @(posedge ck) begin
        if (we)
            mem[waddr] <= wdata;
        rdata <= mem[raddr];
    end

endmodule

// ==== logic/i2s_clock.sv ====
`timescale 1ns/1ps

module i2s_clock #(
    parameter int divider = 4
) (
    input  logic                   ck,
    input  logic                   arst_n,
    output logic                   en,
    output logic                   sck,
    output logic                   ws,
    output audio_pkg::frame_posn_t frame_posn
);

    logic [$clog2(divider)-1:0] div_cnt;

    assign en = (div_cnt == ($bits(div_cnt))'(divider - 1));

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt    <= '0;
            sck        <= 1'b0;
            ws         <= 1'b0;
            frame_posn <= '0;
        end else begin
            if (en)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;

            if (en) begin
                sck <= ~sck;
                // Falling tick moves to the next bit
                if (sck) begin
                    frame_posn <= frame_posn + 1'b1;
                    // ws trails the slot boundary by one bit, as in I2S
                    ws         <= frame_posn[5];
                end
            end
        end
    end

endmodule

// ==== logic/i2s_rx.sv ====
`timescale 1ns/1ps

module i2s_rx (
    input  logic                   ck,
    input  logic                   arst_n,
    input  logic                   en,
    input  logic                   sck,
    input  audio_pkg::frame_posn_t frame_posn,
    input  logic                   sd,
    output audio_pkg::sample_t     left,
    output audio_pkg::sample_t     right
);

    logic [31:0] shreg;
    logic [31:0] shifted;
    logic        rise;

    assign rise    = en && !sck;
    assign shifted = {shreg[30:0], sd};

    always_ff @(posedge ck) begin
        if (rise)
            shreg <= shifted;
    end

    // MSB arrives one bit into the slot, so it lands at index 30
    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            left  <= '0;
            right <= '0;
        end else if (rise) begin
            if (frame_posn == 6'd31)
                left <= shifted[30:15];
            if (frame_posn == 6'd63)
                right <= shifted[30:15];
        end
    end

endmodule

// ==== logic/i2s_tx.sv ====
`timescale 1ns/1ps

module i2s_tx (
    input  logic                   ck,
    input  logic                   arst_n,
    input  logic                   en,
    input  logic                   sck,
    input  audio_pkg::frame_posn_t frame_posn,
    input  audio_pkg::sample_t     left,
    input  audio_pkg::sample_t     right,
    output logic                   sd
);

    logic [15:0] shreg;
    logic        fall;

    assign fall = en && sck;

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            sd    <= 1'b0;
            shreg <= '0;
        end else if (fall) begin
            if (frame_posn == 6'd0) begin
                sd    <= left[15];
                shreg <= {left[14:0], 1'b0};
            end else if (frame_posn == 6'd32) begin
                sd    <= right[15];
                shreg <= {right[14:0], 1'b0};
            end else begin
                // Zeros pad the rest of each 32 bit slot
                sd    <= shreg[15];
                shreg <= {shreg[14:0], 1'b0};
            end
        end
    end

endmodule

// ==== logic/iomem_decode.sv ====
`timescale 1ns/1ps

module iomem_decode #(
    parameter logic [15:0] region_base = 16'h0000
) (
    input  logic                 ck,
    input  logic                 arst_n,
    input  logic                 valid,
    input  logic [3:0]           wstrb,
    input  audio_pkg::bus_word_t addr,
    output logic                 ready,
    output logic                 we,
    output logic                 re
);

    logic seen;
    logic hit;

    // Only the first cycle of a matching access counts while valid is held
    assign hit = valid && !seen && (addr[15:8] == region_base[15:8]);

    // Strobes act on the edge that raises ready
    assign we = hit && (wstrb != 4'h0);
    assign re = hit && (wstrb == 4'h0);

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            seen  <= 1'b0;
            ready <= 1'b0;
        end else begin
            ready <= hit;
            // Cleared once the host drops valid
            seen  <= valid && (seen || hit);
        end
    end

    // The seen flag relies on a request that stays put until it is answered
    a_held_request: assert property (@(posedge ck) disable iff (!arst_n)
        valid && !ready |=> !valid || ($stable(addr) && $stable(wstrb)));

endmodule

// ==== logic/mix_sequencer.sv ====
`timescale 1ns/1ps

module mix_sequencer (
    input  logic                   ck,
    input  logic                   arst_n,
    input  logic                   run_rst,
    input  audio_pkg::frame_t      frame,
    output audio_pkg::coef_addr_t  coef_addr,
    input  audio_pkg::coef_t       coef_data,
    output audio_pkg::audio_addr_t audio_addr,
    input  audio_pkg::sample_t     audio_data,
    output logic                   out_sel,
    output audio_pkg::sample_t     out_data,
    output logic                   out_we,
    output logic                   done,
    output logic                   error
);

    audio_pkg::seq_state_t state;
    logic [3:0]            step;
    logic                  armed;
    // d stage holds the RAM data, p stage the product
    logic                  d_v;
    logic                  p_v;
    logic [3:0]            d_step;
    logic [3:0]            p_step;
    logic signed [31:0]    prod;
    audio_pkg::acc_t       acc;
    audio_pkg::acc_t       sum;
    audio_pkg::acc_t       scaled;
    audio_pkg::sample_t    coef_q15;
    audio_pkg::sample_t    sat_val;
    logic                  sat_hit;
    logic                  last_chan;

    // Step holds the output index above the channel index
    assign coef_addr  = audio_pkg::coef_addr_t'(step);
    assign audio_addr = {step[2:0], frame};
    assign coef_q15   = coef_data[15:0];

    // Channel 0 restarts the sum for each output
    assign sum       = (p_step[2:0] == 3'd0) ? audio_pkg::acc_t'(prod) : acc + prod;
    assign scaled    = sum >>> 15;
    assign last_chan = p_v && (p_step[2:0] == 3'd7);

    always_comb begin
        sat_hit = 1'b1;
        if (scaled > audio_pkg::acc_t'(32767)) begin
            sat_val = 16'sh7fff;
        end else if (scaled < audio_pkg::acc_t'(-32768)) begin
            sat_val = 16'sh8000;
        end else begin
            sat_val = scaled[15:0];
            sat_hit = 1'b0;
        end
    end

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            state  <= audio_pkg::IDLE;
            step   <= '0;
            armed  <= 1'b0;
            d_v    <= 1'b0;
            p_v    <= 1'b0;
            out_we <= 1'b0;
            done   <= 1'b0;
            error  <= 1'b0;
        end else if (run_rst) begin
            // A run starts once run_rst lets go
            state  <= audio_pkg::IDLE;
            step   <= '0;
            armed  <= 1'b1;
            d_v    <= 1'b0;
            p_v    <= 1'b0;
            out_we <= 1'b0;
            done   <= 1'b0;
            error  <= 1'b0;
        end else begin
            d_v    <= (state == audio_pkg::RUN);
            p_v    <= d_v;
            out_we <= last_chan;
            if (last_chan && sat_hit)
                error <= 1'b1;

            case (state)
                audio_pkg::IDLE: begin
                    if (armed) begin
                        armed <= 1'b0;
                        state <= audio_pkg::RUN;
                    end
                end
                audio_pkg::RUN: begin
                    step <= step + 1'b1;
                    if (step == 4'd15)
                        state <= audio_pkg::DRAIN;
                end
                audio_pkg::DRAIN: begin
                    if (!d_v && !p_v)
                        state <= audio_pkg::FINISH;
                end
                default: begin
                    done  <= 1'b1;
                    state <= audio_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge ck) begin
        d_step <= step;
        p_step <= d_step;
        prod   <= coef_q15 * audio_data;
        if (p_v)
            acc <= sum;
        if (last_chan) begin
            out_data <= sat_val;
            out_sel  <= p_step[3];
        end
    end

    a_we_in_run: assert property (@(posedge ck) disable iff (!arst_n)
        out_we |-> state != audio_pkg::IDLE);

endmodule

// ==== verification/audio_engine_tb.sv ====
`timescale 1ns/1ps
`include "audio_cfg.svh"

module audio_engine_tb;

    localparam int entries = 6;
    localparam logic [15:0] mic_left_word  = 16'ha5c3;
    localparam logic [15:0] mic_right_word = 16'h3c5a;
    // Host frame for every mix, captured earlier with both mic words in place
    localparam logic [7:0] mix_frame = 8'd3;

    logic                 ck;
    logic                 arst_n;
    logic                 iomem_valid;
    logic                 iomem_ready;
    logic [3:0]           iomem_wstrb;
    audio_pkg::bus_word_t iomem_addr;
    audio_pkg::bus_word_t iomem_wdata;
    audio_pkg::bus_word_t iomem_rdata;
    logic                 sck;
    logic                 ws;
    logic                 sd_out;
    logic                 sd_in0;

    int errors;
    int seed;

    // Stimulus and expected results, one row per mix run
    logic [15:0] tbl_coef  [entries][16];
    logic [15:0] tbl_ch1   [entries];
    logic [15:0] tbl_left  [entries];
    logic [15:0] tbl_right [entries];
    logic        tbl_err   [entries];

    logic last_ws;
    int   bit_cnt;

    audio_engine uut (
        .ck(ck), .arst_n(arst_n), .iomem_valid(iomem_valid), .iomem_ready(iomem_ready),
        .iomem_wstrb(iomem_wstrb), .iomem_addr(iomem_addr), .iomem_wdata(iomem_wdata),
        .iomem_rdata(iomem_rdata), .sck(sck), .ws(ws), .sd_out(sd_out), .sd_in0(sd_in0));

    always #10 ck = ~ck;

    // Microphone model, MSB on the falling sck edge that changes ws
    always @(negedge sck) begin
        #2;
        if (ws !== last_ws)
            bit_cnt = 0;
        last_ws = ws;
        if (bit_cnt < 16)
            sd_in0 = ws ? mic_right_word[15 - bit_cnt] : mic_left_word[15 - bit_cnt];
        else
            sd_in0 = 1'b0;
        bit_cnt = bit_cnt + 1;
    end

    task automatic access(input audio_pkg::bus_word_t addr, input logic [3:0] strb,
                          input audio_pkg::bus_word_t data,
                          output audio_pkg::bus_word_t rdata, output logic got);
        int n;
        @(posedge ck);
        #2;
        iomem_addr  = addr;
        iomem_wstrb = strb;
        iomem_wdata = data;
        iomem_valid = 1'b1;
        got         = 1'b0;
        rdata       = '0;
        for (n = 0; n < 16 && !got; n++) begin
            @(posedge ck);
            #1;
            if (iomem_ready) begin
                got   = 1'b1;
                rdata = iomem_rdata;
            end
        end
        #1;
        iomem_valid = 1'b0;
        iomem_wstrb = 4'h0;
    endtask

    task automatic bus_write(input audio_pkg::bus_word_t addr, input audio_pkg::bus_word_t data);
        audio_pkg::bus_word_t rd;
        logic                 got;
        access(addr, 4'hf, data, rd, got);
        if (!got) begin
            $display("Timeout at %0t: write to %h got no ready", $time, addr);
            errors++;
        end
    endtask

    task automatic bus_read(input audio_pkg::bus_word_t addr, output audio_pkg::bus_word_t data);
        logic got;
        access(addr, 4'h0, '0, data, got);
        if (!got) begin
            $display("Timeout at %0t: read from %h got no ready", $time, addr);
            errors++;
        end
    endtask

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic wait_ws(input logic level, output logic ok);
        logic prev;
        int   n;
        prev = ws;
        ok   = 1'b0;
        for (n = 0; n < 1200 && !ok; n++) begin
            @(posedge ck);
            #1;
            if (ws == level && prev != level)
                ok = 1'b1;
            prev = ws;
        end
        if (!ok) begin
            $display("Timeout at %0t: ws never changed to %0b", $time, level);
            errors++;
        end
    endtask

    task automatic wait_sck_rise(output logic ok);
        logic prev;
        int   n;
        prev = sck;
        ok   = 1'b0;
        for (n = 0; n < 16 && !ok; n++) begin
            @(posedge ck);
            #1;
            if (sck && !prev)
                ok = 1'b1;
            prev = sck;
        end
        if (!ok) begin
            $display("Timeout at %0t: sck stopped toggling", $time);
            errors++;
        end
    endtask

    // Q1.15 gain times sample, summed per output, scaled and clamped
    task automatic compute_expected(input int e);
        logic [15:0] samp [8];
        logic [15:0] out_word;
        longint      acc;
        longint      cw;
        longint      sw;
        int          k;
        int          c;
        samp[0] = mic_left_word;
        samp[1] = tbl_ch1[e];
        for (c = 2; c < 8; c++)
            samp[c] = 16'h7fff;
        tbl_err[e] = 1'b0;
        for (k = 0; k < 2; k++) begin
            acc = 0;
            for (c = 0; c < 8; c++) begin
                cw  = $signed(tbl_coef[e][k * 8 + c]);
                sw  = $signed(samp[c]);
                acc = acc + cw * sw;
            end
            acc = acc >>> 15;
            if (acc > 32767) begin
                out_word   = 16'h7fff;
                tbl_err[e] = 1'b1;
            end else if (acc < -32768) begin
                out_word   = 16'h8000;
                tbl_err[e] = 1'b1;
            end else begin
                out_word = acc[15:0];
            end
            if (k == 0)
                tbl_left[e] = out_word;
            else
                tbl_right[e] = out_word;
        end
    endtask

    task automatic build_table();
        int e;
        int i;
        for (e = 0; e < entries; e++) begin
            for (i = 0; i < 16; i++)
                tbl_coef[e][i] = 16'h0000;
            tbl_ch1[e] = 16'h0000;
        end
        tbl_coef[0][0] = 16'h4000;
        tbl_coef[0][1] = 16'h2000;
        tbl_coef[0][9] = 16'h7fff;
        tbl_ch1[0]     = 16'h1234;
        // Small random gains keep both sums inside full scale
        for (i = 0; i < 16; i++) begin
            tbl_coef[1][i] = 16'($random(seed) % 4096);
            tbl_coef[3][i] = 16'($random(seed) % 4096);
        end
        tbl_ch1[1] = 16'($random(seed));
        tbl_ch1[3] = 16'($random(seed));
        // Full gain on the six constant channels overflows both outputs
        for (i = 2; i < 8; i++) begin
            tbl_coef[2][i]     = 16'h7fff;
            tbl_coef[2][i + 8] = 16'h7fff;
            tbl_coef[4][i]     = 16'h8000;
            tbl_coef[4][i + 8] = 16'h8000;
        end
        tbl_ch1[2]     = 16'h7fff;
        tbl_ch1[4]     = 16'h8000;
        tbl_coef[5][0] = 16'hc000;
        tbl_coef[5][8] = 16'h0001;
        tbl_ch1[5]     = 16'hffff;
        for (e = 0; e < entries; e++)
            compute_expected(e);
    endtask

    task automatic run_entry(input int e);
        audio_pkg::bus_word_t rd;
        audio_pkg::bus_word_t in_addr;
        logic                 done_seen;
        int                   i;
        int                   n;
        bus_write(`AE_BASE + `AE_STATUS_OFS, {23'd0, mix_frame, 1'b1});
        // Upper half of each coefficient word is ignored by the mixer
        for (i = 0; i < 16; i++)
            bus_write(`AE_BASE + `AE_COEF_OFS + 4 * i, {~tbl_coef[e][i], tbl_coef[e][i]});
        // Channel 1 of a frame below 64 falls inside the input page
        in_addr = `AE_BASE | (32'({3'd1, mix_frame}) << 2);
        bus_write(in_addr, {16'h0000, tbl_ch1[e]});
        bus_write(`AE_BASE + `AE_RESET_OFS, 32'h1);
        done_seen = 1'b0;
        for (n = 0; n < 40 && !done_seen; n++) begin
            bus_read(`AE_BASE + `AE_STATUS_OFS, rd);
            done_seen = rd[0];
        end
        if (!done_seen) begin
            $display("Timeout at %0t: mix run %0d never reported done", $time, e);
            errors++;
        end
        bus_read(`AE_BASE + `AE_RESULT_OFS, rd);
        compare_word($sformatf("left result of entry %0d", e), rd, {16'h0000, tbl_left[e]});
        bus_read(`AE_BASE + `AE_RESULT_OFS + 4, rd);
        compare_word($sformatf("right result of entry %0d", e), rd, {16'h0000, tbl_right[e]});
        bus_read(`AE_BASE + `AE_STATUS_OFS, rd);
        compare_word($sformatf("status of entry %0d", e), rd, {30'd0, tbl_err[e], 1'b1});
    endtask

    task automatic check_tx(input logic [15:0] exp_left, input logic [15:0] exp_right);
        logic [31:0] bits;
        logic        ok;
        int          i;
        bits = '0;
        wait_ws(1'b0, ok);
        for (i = 0; i < 16; i++) begin
            wait_sck_rise(ok);
            bits = {bits[30:0], sd_out};
        end
        wait_ws(1'b1, ok);
        for (i = 0; i < 16; i++) begin
            wait_sck_rise(ok);
            bits = {bits[30:0], sd_out};
        end
        compare_word("I2S transmit pair", bits, {exp_left, exp_right});
    endtask

    initial begin
        audio_pkg::bus_word_t rd;
        logic                 got;
        logic                 ok;
        int                   e;
        int                   n;
        ck          = 1'b0;
        arst_n      = 1'b0;
        iomem_valid = 1'b0;
        iomem_wstrb = 4'h0;
        iomem_addr  = '0;
        iomem_wdata = '0;
        sd_in0      = 1'b0;
        last_ws     = 1'b0;
        bit_cnt     = 16;
        errors      = 0;
        seed        = 59920;
        build_table();
        repeat (8) @(posedge ck);
        #2;
        arst_n = 1'b1;

        if (iomem_ready !== 1'b0) begin
            $display("MISMATCH at %0t: iomem_ready high after reset", $time);
            errors++;
        end
        bus_read(`AE_BASE + `AE_STATUS_OFS, rd);
        compare_word("status word 0 after reset", rd, 32'h0);
        bus_read(`AE_BASE + `AE_RESULT_OFS, rd);
        compare_word("left result after reset", rd, 32'h0);

        // Nothing decodes offset 500, so no ready may come back
        access(`AE_BASE + 16'h0500, 4'h0, '0, rd, got);
        if (got) begin
            $display("Read at unmapped offset 500 was answered with a ready");
            errors++;
        end
        bus_read(`AE_BASE + `AE_STATUS_OFS + 4, rd);
        compare_word("mic pair before any I2S frame", rd, 32'h0);

        // Let capture fill a few frames with the mic pair
        for (n = 0; n < 5; n++)
            wait_ws(1'b0, ok);
        bus_read(`AE_BASE + `AE_STATUS_OFS + 4, rd);
        compare_word("mic pair", rd, {mic_right_word, mic_left_word});

        for (e = 0; e < entries; e++)
            run_entry(e);

        check_tx(tbl_left[entries - 1], tbl_right[entries - 1]);

        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
